// File: src/icache_pkg.sv
// ----------------------------------------------------------------------
// shared constants and types for the read-only instruction cache
// word and address widths, default geometry, FSM state encodings
// modules pull these in with a wildcard import in their body
// ----------------------------------------------------------------------
`default_nettype none

package icache_pkg;

  // datapath widths
  localparam int XLEN  = 32;
  localparam int ADR_W = 32;

  // default geometry, 2 ways x 16 sets x 4 words = 512 bytes
  localparam int DEF_WAYS       = 2;
  localparam int DEF_SETS       = 16;
  localparam int DEF_LINE_WORDS = 4;

  typedef logic [XLEN-1:0]  word_t;
  typedef logic [ADR_W-1:0] adr_t;

  // lookup / fill / flush controller
  typedef enum logic [1:0] {
    ARMED,    // lookup, ack on hit
    FLUSH,    // valid bits just cleared, re-read pending index
    FILL,     // waiting on refill engine
    RECOVER   // one cycle re-read after the line write
  } ctrl_state_e;

  // bus side of the refill engine
  typedef enum logic [1:0] {
    IDLE,
    WAIT4BUS, // strobe out, waiting for strobe ack
    BURST     // collecting beats
  } refill_state_e;

endpackage

`default_nettype wire

// File: src/icache_victim_lfsr.sv
// ----------------------------------------------------------------------
// pseudo-random replacement
// 20-bit XNOR LFSR, stepped every cycle outside a fill, low bits
// decoded to a one-hot victim way
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module icache_victim_lfsr #(
  parameter int WAYS = icache_pkg::DEF_WAYS
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            filling_i,
  output logic [WAYS-1:0] victim_o
);

  localparam int WAY_W = (WAYS > 1) ? $clog2(WAYS) : 1;

  logic [19:0] lfsr_q; // all zero is a legal XNOR state

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      lfsr_q <= '0;
    else if (!filling_i)
      lfsr_q <= {lfsr_q[18:0], lfsr_q[19] ~^ lfsr_q[16]}; // taps 20,17
  end

  // modulo keeps non power of two way counts in range
  assign victim_o = WAYS'(1) << (lfsr_q[WAY_W-1:0] % WAYS);

endmodule

`default_nettype wire

// File: src/icache_tag_array.sv
// ----------------------------------------------------------------------
// tag store, one valid bit and one tag register per way and set
// read index and requested tag are registered, hit vector is
// compared in the following cycle
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module icache_tag_array #(
  parameter int WAYS       = icache_pkg::DEF_WAYS,
  parameter int SETS       = icache_pkg::DEF_SETS,
  parameter int LINE_WORDS = icache_pkg::DEF_LINE_WORDS,
  localparam int IDX_W     = $clog2(SETS),
  localparam int TAG_W     = icache_pkg::ADR_W - IDX_W - $clog2(LINE_WORDS)
                             - $clog2(icache_pkg::XLEN / 8)
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [IDX_W-1:0] rd_idx_i,
  input  logic [TAG_W-1:0] rd_tag_i,
  input  logic [IDX_W-1:0] wr_idx_i,
  input  logic [WAYS-1:0]  tag_we_i,
  input  logic [TAG_W-1:0] tag_i,
  input  logic             flush_clr_i,
  output logic [WAYS-1:0]  hit_o
);

  logic [IDX_W-1:0] rd_idx_q;
  logic [TAG_W-1:0] rd_tag_q;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      rd_idx_q <= '0;
    else
      rd_idx_q <= rd_idx_i;
  end

  always_ff @(posedge clk_i)
  begin
    rd_tag_q <= rd_tag_i; // compared against all ways
  end

  for (genvar w = 0; w < WAYS; w++)
  begin : g_way
    logic [SETS-1:0]  valid_q;
    logic [TAG_W-1:0] tag_q [SETS];

    // flush wins, controller never writes during a flush
    always_ff @(posedge clk_i or negedge rst_ni)
    begin
      if (!rst_ni)
        valid_q <= '0;
      else if (flush_clr_i)
        valid_q <= '0;
      else if (tag_we_i[w])
        valid_q[wr_idx_i] <= 1'b1;
    end

    always_ff @(posedge clk_i)
    begin
      if (tag_we_i[w])
        tag_q[wr_idx_i] <= tag_i;
    end

    // valid taken live so a flush shows up immediately
    assign hit_o[w] = valid_q[rd_idx_q] & (tag_q[rd_idx_q] == rd_tag_q);
  end

endmodule

`default_nettype wire

// File: src/icache_data_array.sv
// ----------------------------------------------------------------------
// line store, one full line per way and set
// every way is read at the clock edge, the hit vector then picks
// the way and the registered word offset picks the word
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module icache_data_array #(
  parameter int WAYS       = icache_pkg::DEF_WAYS,
  parameter int SETS       = icache_pkg::DEF_SETS,
  parameter int LINE_WORDS = icache_pkg::DEF_LINE_WORDS,
  localparam int IDX_W     = $clog2(SETS),
  localparam int WORD_BITS = $clog2(LINE_WORDS),
  localparam int LINE_W    = LINE_WORDS * icache_pkg::XLEN
) (
  input  logic                 clk_i,
  input  logic [IDX_W-1:0]     rd_idx_i,
  input  logic [IDX_W-1:0]     wr_idx_i,
  input  logic [WAYS-1:0]      dat_we_i,
  input  logic [LINE_W-1:0]    line_i,
  input  logic [WAYS-1:0]      hit_i,
  input  logic [WORD_BITS-1:0] word_sel_i,
  output icache_pkg::word_t    q_o
);
  import icache_pkg::*;

  logic [LINE_W-1:0]    way_sel [WAYS]; // masked by hit
  logic [LINE_W-1:0]    hit_line;
  logic [WORD_BITS-1:0] word_sel_q;

  for (genvar w = 0; w < WAYS; w++)
  begin : g_way
    logic [LINE_W-1:0] line_q [SETS];
    logic [LINE_W-1:0] rd_q;

    always_ff @(posedge clk_i)
    begin
      if (dat_we_i[w])
        line_q[wr_idx_i] <= line_i;
      rd_q <= line_q[rd_idx_i]; // old data if same set is written
    end

    assign way_sel[w] = rd_q & {LINE_W{hit_i[w]}};
  end

  // AND-OR way mux, hit is one-hot
  always_comb
  begin
    hit_line = '0;
    for (int w = 0; w < WAYS; w++)
      hit_line = hit_line | way_sel[w];
  end

  always_ff @(posedge clk_i)
  begin
    word_sel_q <= word_sel_i;
  end

  assign q_o = hit_line[word_sel_q*XLEN +: XLEN];

endmodule

`default_nettype wire

// File: src/icache_refill.sv
// ----------------------------------------------------------------------
// line refill engine
// issues one strobe per miss, waits for strobe ack, then collects an
// incrementing burst of LINE_WORDS beats into the line buffer
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module icache_refill #(
  parameter int LINE_WORDS = icache_pkg::DEF_LINE_WORDS,
  localparam int LINE_W    = LINE_WORDS * icache_pkg::XLEN
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // controller
  input  logic              fill_req_i,
  input  icache_pkg::adr_t  fill_adr_i,
  output logic              fill_done_o,
  output logic              fill_err_o,
  output logic [LINE_W-1:0] line_o,
  // memory bus
  output logic              bus_stb_o,
  output icache_pkg::adr_t  bus_adr_o,
  input  logic              bus_stb_ack_i,
  input  icache_pkg::word_t bus_q_i,
  input  logic              bus_ack_i,
  input  logic              bus_err_i
);
  import icache_pkg::*;

  localparam int WORD_BITS = $clog2(LINE_WORDS);
  localparam int OFF_W     = WORD_BITS + $clog2(XLEN / 8);

  refill_state_e        state_q;
  logic [WORD_BITS-1:0] beat_cnt_q; // beats still to come after this one
  logic [WORD_BITS-1:0] slot;       // word position of the current beat
  logic                 last_beat;
  logic                 beat;
  adr_t                 bus_adr_q;
  logic [LINE_W-1:0]    line_q;

  assign beat      = (state_q == BURST) & bus_ack_i;
  assign last_beat = beat & (beat_cnt_q == '0);
  assign slot      = WORD_BITS'(LINE_WORDS - 1) - beat_cnt_q; // ascending order

  // ------------------------------------------------------------------
  // bus FSM
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q    <= IDLE;
      beat_cnt_q <= '0;
    end
    else
    begin
      case (state_q)
        IDLE:
          if (fill_req_i)
          begin
            state_q    <= WAIT4BUS;
            beat_cnt_q <= WORD_BITS'(LINE_WORDS - 1);
          end
        WAIT4BUS:
          if (bus_stb_ack_i)
            state_q <= BURST; // strobe accepted
        BURST:
          if (bus_err_i || last_beat)
            state_q <= IDLE;
          else if (bus_ack_i)
            beat_cnt_q <= beat_cnt_q - 1'b1;
        default: state_q <= IDLE;
      endcase
    end
  end

  // strobe and address held under back-pressure
  always_ff @(posedge clk_i)
  begin
    if (state_q == IDLE && fill_req_i)
      bus_adr_q <= {fill_adr_i[ADR_W-1:OFF_W], OFF_W'(0)}; // line aligned
  end

  assign bus_stb_o = (state_q == WAIT4BUS);
  assign bus_adr_o = bus_adr_q;

  assign fill_done_o = last_beat & ~bus_err_i;
  assign fill_err_o  = (state_q == BURST) & bus_err_i;

  // ------------------------------------------------------------------
  // line assembly
  // ------------------------------------------------------------------
  always_comb
  begin
    line_o = line_q;
    if (beat)
      line_o[slot*XLEN +: XLEN] = bus_q_i; // final beat goes straight through
  end

  always_ff @(posedge clk_i)
  begin
    if (beat)
      line_q <= line_o;
  end

endmodule

`default_nettype wire

// File: src/icache_ctrl_fsm.sv
// ----------------------------------------------------------------------
// cache controller
// tracks the one outstanding fetch, runs lookup / fill / flush,
// drives the array read index and the tag/data write strobes
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl_fsm #(
  parameter int WAYS       = icache_pkg::DEF_WAYS,
  parameter int SETS       = icache_pkg::DEF_SETS,
  parameter int LINE_WORDS = icache_pkg::DEF_LINE_WORDS,
  localparam int IDX_W     = $clog2(SETS),
  localparam int TAG_W     = icache_pkg::ADR_W - IDX_W - $clog2(LINE_WORDS)
                             - $clog2(icache_pkg::XLEN / 8)
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  // fetch side
  input  logic             mem_req_i,
  input  icache_pkg::adr_t mem_adr_i,
  output logic             mem_ack_o,
  output logic             mem_err_o,
  input  logic             flush_i,
  // lookup and replacement
  input  logic [WAYS-1:0]  hit_i,
  input  logic [WAYS-1:0]  victim_i,
  // refill engine
  output logic             fill_req_o,
  output icache_pkg::adr_t fill_adr_o,
  input  logic             fill_done_i,
  input  logic             fill_err_i,
  output logic             filling_o,
  // array control
  output logic [IDX_W-1:0] rd_idx_o,
  output logic [IDX_W-1:0] wr_idx_o,
  output logic [WAYS-1:0]  tag_we_o,
  output logic [WAYS-1:0]  dat_we_o,
  output logic [TAG_W-1:0] tag_o,
  output logic             flush_clr_o
);
  import icache_pkg::*;

  localparam int OFF_W = $clog2(LINE_WORDS) + $clog2(XLEN / 8);

  ctrl_state_e      state_q;
  ctrl_state_e      state_d;
  logic             req_q;        // request sampled, not yet answered
  adr_t             adr_q;        // its address
  logic             flush_hold_q; // flush seen while busy
  logic             flush_pend;
  logic             hit;
  logic             wr_line;
  logic [WAYS-1:0]  victim_q;
  logic [IDX_W-1:0] fill_idx_q;
  logic [TAG_W-1:0] fill_tag_q;

  assign hit        = |hit_i;
  assign flush_pend = flush_i | flush_hold_q;

  // ------------------------------------------------------------------
  // requester handshake
  // ------------------------------------------------------------------
  assign mem_ack_o = (state_q == ARMED) & req_q & hit; // lookup was done last edge
  assign mem_err_o = (state_q == FILL) & fill_err_i;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      req_q <= 1'b0;
    else
      req_q <= mem_req_i | (req_q & ~(mem_ack_o | mem_err_o)); // next may start on the response
  end

  always_ff @(posedge clk_i)
  begin
    if (mem_req_i)
      adr_q <= mem_adr_i; // requester keeps it stable until answered
  end

  // flush only acts in ARMED, otherwise wait for it
  assign flush_clr_o = (state_q == ARMED) & flush_pend;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      flush_hold_q <= 1'b0;
    else
      flush_hold_q <= flush_pend & ~flush_clr_o;
  end

  // ------------------------------------------------------------------
  // lookup / fill / flush FSM
  // ------------------------------------------------------------------
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ARMED:
        if (flush_pend)
          state_d = FLUSH;
        else if (req_q && !hit)
          state_d = FILL;
      FLUSH:   state_d = ARMED;
      FILL:
        if (fill_done_i || fill_err_i)
          state_d = RECOVER; // re-read before serving again
      RECOVER: state_d = ARMED;
      default: state_d = ARMED;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      state_q <= ARMED;
    else
      state_q <= state_d;
  end

  assign filling_o  = (state_q == FILL);
  assign fill_req_o = (state_q == ARMED) & req_q & ~hit & ~flush_pend;
  assign fill_adr_o = adr_q;

  // victim way and line tag fixed for the whole fill
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      victim_q <= '0;
    else if (fill_req_o)
      victim_q <= victim_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (fill_req_o)
    begin
      fill_idx_q <= adr_q[OFF_W +: IDX_W];
      fill_tag_q <= adr_q[ADR_W-1 -: TAG_W];
    end
  end

  // ------------------------------------------------------------------
  // array control
  // ------------------------------------------------------------------
  // pending address outside ARMED, so RECOVER/FLUSH re-read the right set
  assign rd_idx_o = (state_q != ARMED && req_q) ? adr_q[OFF_W +: IDX_W]
                                                : mem_adr_i[OFF_W +: IDX_W];

  assign wr_line  = filling_o & fill_done_i; // nothing written on error
  assign tag_we_o = victim_q & {WAYS{wr_line}};
  assign dat_we_o = victim_q & {WAYS{wr_line}};
  assign wr_idx_o = fill_idx_q;
  assign tag_o    = fill_tag_q;

endmodule

`default_nettype wire

// File: src/icache_top.sv
// ----------------------------------------------------------------------
// instruction cache top level
// connects controller, refill engine, tag/data arrays and victim LFSR
// geometry is set here and handed down to every block
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
  parameter int WAYS       = icache_pkg::DEF_WAYS,
  parameter int SETS       = icache_pkg::DEF_SETS,
  parameter int LINE_WORDS = icache_pkg::DEF_LINE_WORDS
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  // fetch side
  input  logic             mem_req_i,
  input  icache_pkg::adr_t mem_adr_i,
  output icache_pkg::word_t mem_q_o,
  output logic             mem_ack_o,
  output logic             mem_err_o,
  input  logic             flush_i,
  // memory bus
  output logic             bus_stb_o,
  output icache_pkg::adr_t bus_adr_o,
  input  logic             bus_stb_ack_i,
  input  icache_pkg::word_t bus_q_i,
  input  logic             bus_ack_i,
  input  logic             bus_err_i
);
  import icache_pkg::*;

  localparam int IDX_W     = $clog2(SETS);
  localparam int WORD_BITS = $clog2(LINE_WORDS);
  localparam int BYTE_BITS = $clog2(XLEN / 8);
  localparam int TAG_W     = ADR_W - IDX_W - WORD_BITS - BYTE_BITS;
  localparam int LINE_W    = LINE_WORDS * XLEN;

  logic [WAYS-1:0]   hit;       // one-hot, registered lookup
  logic [WAYS-1:0]   victim;
  logic              fill_req;
  adr_t              fill_adr;
  logic              fill_done;
  logic              fill_err;
  logic              filling;
  logic [IDX_W-1:0]  rd_idx;
  logic [IDX_W-1:0]  wr_idx;
  logic [WAYS-1:0]   tag_we;
  logic [WAYS-1:0]   dat_we;
  logic [TAG_W-1:0]  wr_tag;
  logic              flush_clr;
  logic [LINE_W-1:0] fill_line; // assembled line incl. last beat

  icache_ctrl_fsm #(.WAYS(WAYS), .SETS(SETS), .LINE_WORDS(LINE_WORDS)) u_ctrl (
    .clk_i, .rst_ni,
    .mem_req_i, .mem_adr_i, .mem_ack_o, .mem_err_o, .flush_i,
    .hit_i(hit), .victim_i(victim),
    .fill_req_o(fill_req), .fill_adr_o(fill_adr), .fill_done_i(fill_done),
    .fill_err_i(fill_err), .filling_o(filling),
    .rd_idx_o(rd_idx), .wr_idx_o(wr_idx), .tag_we_o(tag_we), .dat_we_o(dat_we),
    .tag_o(wr_tag), .flush_clr_o(flush_clr)
  );

  icache_refill #(.LINE_WORDS(LINE_WORDS)) u_refill (
    .clk_i, .rst_ni,
    .fill_req_i(fill_req), .fill_adr_i(fill_adr),
    .fill_done_o(fill_done), .fill_err_o(fill_err), .line_o(fill_line),
    .bus_stb_o, .bus_adr_o, .bus_stb_ack_i, .bus_q_i, .bus_ack_i, .bus_err_i
  );

  // requested tag and word offset come straight off the held request
  icache_tag_array #(.WAYS(WAYS), .SETS(SETS), .LINE_WORDS(LINE_WORDS)) u_tags (
    .clk_i, .rst_ni,
    .rd_idx_i(rd_idx), .rd_tag_i(mem_adr_i[ADR_W-1 -: TAG_W]),
    .wr_idx_i(wr_idx), .tag_we_i(tag_we), .tag_i(wr_tag), .flush_clr_i(flush_clr),
    .hit_o(hit)
  );

  icache_data_array #(.WAYS(WAYS), .SETS(SETS), .LINE_WORDS(LINE_WORDS)) u_data (
    .clk_i,
    .rd_idx_i(rd_idx), .wr_idx_i(wr_idx), .dat_we_i(dat_we), .line_i(fill_line),
    .hit_i(hit), .word_sel_i(mem_adr_i[BYTE_BITS +: WORD_BITS]),
    .q_o(mem_q_o)
  );

  icache_victim_lfsr #(.WAYS(WAYS)) u_victim (
    .clk_i, .rst_ni, .filling_i(filling), .victim_o(victim)
  );

endmodule

`default_nettype wire

// File: sim/icache_props.sv
// ----------------------------------------------------------------------
// handshake properties for the instruction cache
// bound into the top level, reports only through failing assertions
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module icache_props (
  input logic             clk_i,
  input logic             rst_ni,
  input logic             mem_req_i,
  input logic             mem_ack_o,
  input logic             mem_err_o,
  input logic             bus_stb_o,
  input icache_pkg::adr_t bus_adr_o,
  input logic             bus_stb_ack_i
);

  // strobe and address held until accepted
  stb_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (bus_stb_o && !bus_stb_ack_i) |=> (bus_stb_o && $stable(bus_adr_o))
  ) else $error("bus strobe or address changed before strobe ack");

  // one response kind at a time
  resp_excl: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(mem_ack_o && mem_err_o)
  ) else $error("mem_ack_o and mem_err_o high together");

  // response only for a request seen at the edge that opened its cycle
  resp_has_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (mem_ack_o || mem_err_o) |-> $past(mem_req_i)
  ) else $error("response without an outstanding request");

  // quiet right after reset
  reset_quiet: assert property (
    @(posedge clk_i)
    $rose(rst_ni) |-> (!mem_ack_o && !mem_err_o && !bus_stb_o)
  ) else $error("outputs active when leaving reset");

endmodule

bind icache_top icache_props u_props (
  .clk_i, .rst_ni, .mem_req_i, .mem_ack_o, .mem_err_o,
  .bus_stb_o, .bus_adr_o, .bus_stb_ack_i
);

`default_nettype wire

// File: sim/tb_icache.sv
// ----------------------------------------------------------------------
// testbench for the instruction cache
// requester and burst memory model around the DUT, with checks done by
// immediate assertions on every response and a watchdog on the run
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_icache;
  import icache_pkg::*;

  localparam int OFF_W       = $clog2(DEF_LINE_WORDS) + $clog2(XLEN / 8);
  localparam int DRIVE_DLY   = 1;  // model drives after the edge
  localparam int SAMPLE_DLY  = 2;  // requester samples and drives after the model
  localparam int NUM_PAIRS   = 24;
  localparam int NUM_REQ     = 2 * NUM_PAIRS + 8;
  localparam int MAX_MISS    = 100; // stalled strobe ack + 4 stalled beats + overhead
  localparam int TIMEOUT_NS  = (NUM_REQ * MAX_MISS + 20) * 10;

  logic  clk_i;
  logic  rst_ni;
  logic  mem_req_i;
  adr_t  mem_adr_i;
  word_t mem_q_o;
  logic  mem_ack_o;
  logic  mem_err_o;
  logic  flush_i;
  logic  bus_stb_o;
  adr_t  bus_adr_o;
  logic  bus_stb_ack_i;
  word_t bus_q_i;
  logic  bus_ack_i;
  logic  bus_err_i;

  // memory model bookkeeping
  logic [31:0] model_rng = 32'd28;
  logic [31:0] stim_rng;
  int          stb_count  = 0;  // accepted strobes
  int          beat_count = 0;  // acknowledged beats
  adr_t        stb_adr;         // address of the last accepted strobe
  int          err_beat   = -1; // beat that gets bus_err_i, -1 none
  bit          long_stall = 0;
  adr_t        last_line;       // most recently filled line
  bit          last_valid = 0;

  icache_top UUT (
    .clk_i, .rst_ni,
    .mem_req_i, .mem_adr_i, .mem_q_o, .mem_ack_o, .mem_err_o, .flush_i,
    .bus_stb_o, .bus_adr_o, .bus_stb_ack_i, .bus_q_i, .bus_ack_i, .bus_err_i
  );

  // 32-bit xorshift, also the memory contents at each address
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    fail_stop($sformatf("MISMATCH %s expected 0x%08h got 0x%08h", name, exp, got));
  endtask

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i; // 10 ns period
  end

  initial
  begin : watchdog
    #(TIMEOUT_NS);
    fail_stop("watchdog timeout, the requests did not complete in time");
  end

  // ------------------------------------------------------------------
  // burst memory model
  // ------------------------------------------------------------------
  initial
  begin : bus_model
    int gap;
    forever
    begin
      @(posedge clk_i);
      #(DRIVE_DLY);
      if (bus_stb_o)
      begin
        model_rng = xorshift32(model_rng);
        gap = long_stall ? 8 + int'(model_rng % 8) : int'(model_rng % 4); // back-pressure
        repeat (gap)
        begin
          @(posedge clk_i);
          #(DRIVE_DLY);
        end
        bus_stb_ack_i = 1'b1;
        @(posedge clk_i);
        stb_count++;
        stb_adr = bus_adr_o; // taken on the accepting edge
        #(DRIVE_DLY) bus_stb_ack_i = 1'b0;
        for (int b = 0; b < DEF_LINE_WORDS; b++)
        begin
          model_rng = xorshift32(model_rng);
          gap = long_stall ? 8 + int'(model_rng % 8) : int'(model_rng % 3);
          repeat (gap)
          begin
            @(posedge clk_i);
            #(DRIVE_DLY);
          end
          if (b == err_beat)
          begin
            bus_err_i = 1'b1; // ends the burst
            @(posedge clk_i);
            #(DRIVE_DLY) bus_err_i = 1'b0;
            break;
          end
          bus_ack_i = 1'b1;
          bus_q_i   = xorshift32(stb_adr + 32'(4 * b)); // ascending words
          @(posedge clk_i);
          beat_count++;
          #(DRIVE_DLY);
          bus_ack_i = 1'b0;
          bus_q_i   = '0;
        end
      end
    end
  end

  // ------------------------------------------------------------------
  // requester, one fetch up to its response
  // ------------------------------------------------------------------
  task automatic fetch(input adr_t adr, input bit must_miss);
    int   cycles;
    int   stb0;
    int   beats0;
    int   n_stb;
    bit   exp_err;
    adr_t line_adr;
    line_adr  = {adr[ADR_W-1:OFF_W], OFF_W'(0)};
    exp_err   = (err_beat >= 0);
    stb0      = stb_count;
    beats0    = beat_count;
    cycles    = 0;
    mem_req_i = 1'b1;
    mem_adr_i = adr;
    do
    begin
      @(posedge clk_i);
      #(SAMPLE_DLY);
      cycles++;
    end while (!mem_ack_o && !mem_err_o);
    n_stb = stb_count - stb0;
    // response kind, then data
    assert (mem_err_o == exp_err) else report_mismatch("mem_err_o", 32'(exp_err), 32'(mem_err_o));
    assert (mem_ack_o == !exp_err) else report_mismatch("mem_ack_o", 32'(!exp_err), 32'(mem_ack_o));
    if (!exp_err)
      assert (mem_q_o == xorshift32(adr)) else report_mismatch("mem_q_o", xorshift32(adr), mem_q_o);
    // strobe count per request
    assert (n_stb <= 1) else report_mismatch("bus_stb_o count", 32'd1, 32'(n_stb));
    if (must_miss || exp_err)
      assert (n_stb == 1) else report_mismatch("bus_stb_o count", 32'd1, 32'(n_stb));
    if (last_valid && line_adr == last_line)
    begin
      assert (n_stb == 0) else report_mismatch("bus_stb_o count on hit", 32'd0, 32'(n_stb));
      assert (cycles == 1) else report_mismatch("hit latency", 32'd1, 32'(cycles));
    end
    if (n_stb == 1)
    begin
      assert (stb_adr == line_adr) else report_mismatch("bus_adr_o", line_adr, stb_adr);
      if (!exp_err)
        assert (beat_count - beats0 == DEF_LINE_WORDS)
        else report_mismatch("beat count", 32'(DEF_LINE_WORDS), 32'(beat_count - beats0));
    end
    if (n_stb == 1 && !exp_err)
    begin
      last_line  = line_adr;
      last_valid = 1'b1;
    end
    mem_req_i = 1'b0; // next fetch may start right here
  endtask

  task automatic check_idle();
    assert (!mem_ack_o && !mem_err_o && !bus_stb_o)
    else fail_stop("outputs active during reset or in the first cycle after it");
  endtask

  // ------------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------------
  initial
  begin : stimulus
    adr_t adr;
    adr_t flushed;
    rst_ni        = 1'b0;
    mem_req_i     = 1'b0;
    mem_adr_i     = '0;
    flush_i       = 1'b0;
    bus_stb_ack_i = 1'b0;
    bus_q_i       = '0;
    bus_ack_i     = 1'b0;
    bus_err_i     = 1'b0;
    stim_rng      = xorshift32(32'd28);
    repeat (4)
    begin
      @(posedge clk_i);
      #(DRIVE_DLY);
      check_idle();
    end
    rst_ni = 1'b1;
    @(posedge clk_i);
    #(SAMPLE_DLY);
    check_idle();

    // random lines, three tags on four sets, each followed by a repeat
    for (int i = 0; i < NUM_PAIRS; i++)
    begin
      stim_rng = xorshift32(stim_rng);
      adr = 32'h1000 + (((stim_rng >> 8) % 3) << 8) + (((stim_rng >> 4) & 32'h3) << 4)
            + ((stim_rng & 32'h3) << 2);
      fetch(adr, 1'b0);
      fetch({adr[ADR_W-1:OFF_W], stim_rng[11:10], 2'b00}, 1'b0);
    end

    // flush, then the last filled line has to come from the bus again
    flushed = last_line;
    @(posedge clk_i);
    #(DRIVE_DLY) flush_i = 1'b1;
    @(posedge clk_i);
    #(DRIVE_DLY) flush_i = 1'b0;
    last_valid = 1'b0;
    fetch(flushed + 32'h4, 1'b1);

    // error on the third beat, then a clean retry
    err_beat = 2;
    fetch(32'h3008, 1'b1);
    err_beat = -1;
    fetch(32'h3008, 1'b1);

    // long stalls on strobe ack and between beats
    long_stall = 1'b1;
    fetch(32'h2000, 1'b1);
    fetch(32'h2014, 1'b1);
    long_stall = 1'b0;
    fetch(32'h201c, 1'b0);

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
src/icache_pkg.sv
src/icache_victim_lfsr.sv
src/icache_tag_array.sv
src/icache_data_array.sv
src/icache_refill.sv
src/icache_ctrl_fsm.sv
src/icache_top.sv
sim/icache_props.sv
sim/tb_icache.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, decide pass/fail from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_icache \
  --Mdir obj_dir -o sim_icache || exit 1
./obj_dir/sim_icache > sim.log 2>&1 || true
cat sim.log
grep -q '^Regression passed$' sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
